// ==== bankDrainPkg.sv ====
package bankDrainPkg;

    localparam int NumBanks   = 4;
    localparam int QueueDepth = 8;   // words per bank queue
    localparam int RecDepth   = 8;   // finished-burst records held
    localparam int LenWidth   = 4;

    typedef logic [1:0]  bankIdx_t;
    typedef logic [15:0] bankWord_t;

    // summary of one finished burst
    typedef struct packed {
        bankIdx_t            bank;
        logic [LenWidth-1:0] len;
    } burstRec_t;

    // bank states sit one above their bank number
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        BANK0 = 3'd1,
        BANK1 = 3'd2,
        BANK2 = 3'd3,
        BANK3 = 3'd4
    } arbState_t;

endpackage

// ==== drainIf.sv ====
`timescale 1ns/1ps

interface drainIf;

    logic [bankDrainPkg::NumBanks-1:0] req;   // queue not empty
    logic [bankDrainPkg::NumBanks-1:0] ack;   // one-hot pop strobe
    bankDrainPkg::bankIdx_t            sel;   // bank being drained
    bankDrainPkg::bankWord_t           headWord;
    logic                              en;
    logic                              done;  // burst finished

    modport store (
        output req,
        output headWord,
        input  ack,
        input  sel
    );

    modport arb (
        output ack,
        output sel,
        output en,
        output done,
        input  req
    );

    modport coll (
        input en,
        input done,
        input sel,
        input headWord
    );

endinterface

// ==== bankFifo.sv ====
`timescale 1ns/1ps

module bankFifo #(
    parameter type payload_t = logic [7:0],
    parameter int  Depth     = 8
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t pushData,
    input  logic     pop,
    output payload_t headData,
    output logic     empty,
    output logic     full
);

    localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

    payload_t              mem [Depth];
    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [PtrWidth:0]     count;   // one bit wider to hold Depth

    assign empty    = (count == '0);
    assign full     = (count == (PtrWidth + 1)'(Depth));
    assign headData = mem[rdPtr];   // first-word fall-through

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + (PtrWidth + 1)'(push) - (PtrWidth + 1)'(pop);
        end
    end

    // the writer must watch full, the reader must watch empty
    assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("bankFifo: push while full");
    assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
        else $error("bankFifo: pop while empty");

endmodule

// ==== bankStore.sv ====
`timescale 1ns/1ps

module bankStore (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              wrEn,
    input  bankDrainPkg::bankIdx_t            wrBank,
    input  bankDrainPkg::bankWord_t           wrData,
    output logic [bankDrainPkg::NumBanks-1:0] bankFull,
    drainIf.store                             drain
);

    bankDrainPkg::bankWord_t           heads [bankDrainPkg::NumBanks];
    logic [bankDrainPkg::NumBanks-1:0] emptyVec;
    logic [bankDrainPkg::NumBanks-1:0] pushVec;

    // one write strobe, steered to its bank
    always_comb begin
        pushVec = '0;
        if (wrEn) begin
            pushVec[wrBank] = 1'b1;
        end
    end

    for (genvar b = 0; b < bankDrainPkg::NumBanks; b++) begin : genBank
        bankFifo #(
            .payload_t (bankDrainPkg::bankWord_t),
            .Depth     (bankDrainPkg::QueueDepth)
        ) queue (
            .clk      (clk),
            .rst_n    (rst_n),
            .push     (pushVec[b]),
            .pushData (wrData),
            .pop      (drain.ack[b]),   // popped on the grant edge
            .headData (heads[b]),
            .empty    (emptyVec[b]),
            .full     (bankFull[b])
        );
    end

    assign drain.req      = ~emptyVec;          // any stored word asks for a grant
    assign drain.headWord = heads[drain.sel];   // head of the granted bank

endmodule

// ==== bankGroupArb.sv ====
`timescale 1ns/1ps

module bankGroupArb (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  logic [bankDrainPkg::NumBanks-1:0] bankValid,
    drainIf.arb                               drain
);

    bankDrainPkg::arbState_t state;
    bankDrainPkg::arbState_t nextState;
    bankDrainPkg::bankIdx_t  curBank;
    bankDrainPkg::bankIdx_t  grantIdx;
    logic                    grant;
    logic                    burstDone;

    assign curBank = bankDrainPkg::bankIdx_t'(state - bankDrainPkg::BANK0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= bankDrainPkg::IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        bankDrainPkg::bankIdx_t cand;
        grant     = 1'b0;
        grantIdx  = '0;
        burstDone = 1'b0;
        nextState = state;
        cand      = '0;
        if (start) begin   // frozen while start is low
            if (state == bankDrainPkg::IDLE) begin
                // scan downwards so the lowest requester is kept
                for (int k = bankDrainPkg::NumBanks - 1; k >= 0; k--) begin
                    cand = bankDrainPkg::bankIdx_t'(k);
                    if (drain.req[cand]) begin
                        grant     = 1'b1;
                        grantIdx  = cand;
                        nextState = bankDrainPkg::arbState_t'({1'b0, cand} + 3'd1);
                    end
                end
            end else if (drain.req[curBank] && bankValid[curBank]) begin
                grant    = 1'b1;   // burst carries on
                grantIdx = curBank;
            end else begin
                burstDone = 1'b1;
                nextState = bankDrainPkg::IDLE;
                // round robin, nearest bank after the current one wins
                for (int k = bankDrainPkg::NumBanks - 1; k >= 1; k--) begin
                    cand = curBank + bankDrainPkg::bankIdx_t'(k);
                    if (drain.req[cand]) begin
                        nextState = bankDrainPkg::arbState_t'({1'b0, cand} + 3'd1);
                    end
                end
            end
        end
    end

    assign drain.en   = grant;
    assign drain.sel  = grantIdx;
    assign drain.done = burstDone;
    assign drain.ack  = grant ? (bankDrainPkg::NumBanks'(1) << grantIdx) : '0;

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(drain.ack))
        else $error("bankGroupArb: more than one bank acked");
    assert property (@(posedge clk) disable iff (!rst_n) (|drain.ack) == drain.en)
        else $error("bankGroupArb: ack and en disagree");
    // req comes from the store, so this covers both sides of the grant
    assert property (@(posedge clk) disable iff (!rst_n) (drain.ack & ~drain.req) == '0)
        else $error("bankGroupArb: ack without req");

endmodule

// ==== drainCollector.sv ====
`timescale 1ns/1ps

module drainCollector (
    input  logic                                  clk,
    input  logic                                  rst_n,
    drainIf.coll                                  drain,
    output logic                                  outValid,
    output bankDrainPkg::bankIdx_t                outBank,
    output bankDrainPkg::bankWord_t               outData,
    input  logic                                  recPop,
    output logic                                  recValid,
    output bankDrainPkg::bankIdx_t                recBank,
    output logic [bankDrainPkg::LenWidth-1:0]     recLen
);

    logic [bankDrainPkg::LenWidth-1:0] burstCount;   // words since last done
    bankDrainPkg::bankIdx_t            burstBank;
    bankDrainPkg::burstRec_t           newRec;
    bankDrainPkg::burstRec_t           headRec;
    logic                              recPush;
    logic                              recEmpty;
    logic                              recFull;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outValid   <= 1'b0;
            burstCount <= '0;
        end else begin
            outValid <= drain.en;
            if (drain.done) begin
                burstCount <= '0;
            end else if (drain.en) begin
                burstCount <= burstCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (drain.en) begin
            outBank   <= drain.sel;
            outData   <= drain.headWord;
            burstBank <= drain.sel;
        end
    end

    assign newRec.bank = burstBank;
    assign newRec.len  = burstCount;
    assign recPush     = drain.done && (burstCount != '0) && !recFull;   // lost when full

    bankFifo #(
        .payload_t (bankDrainPkg::burstRec_t),
        .Depth     (bankDrainPkg::RecDepth)
    ) recQueue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (recPush),
        .pushData (newRec),
        .pop      (recPop && !recEmpty),
        .headData (headRec),
        .empty    (recEmpty),
        .full     (recFull)
    );

    assign recValid = !recEmpty;
    assign recBank  = headRec.bank;
    assign recLen   = headRec.len;

    // a burst never switches bank before its done
    assert property (@(posedge clk) disable iff (!rst_n)
        (drain.en && burstCount != '0) |-> drain.sel == burstBank)
        else $error("drainCollector: bank changed inside a burst");

endmodule

// ==== bankDrainTop.sv ====
`timescale 1ns/1ps

module bankDrainTop (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  wrEn,
    input  bankDrainPkg::bankIdx_t                wrBank,
    input  bankDrainPkg::bankWord_t               wrData,
    input  logic [bankDrainPkg::NumBanks-1:0]     bankValid,
    input  logic                                  start,
    output logic [bankDrainPkg::NumBanks-1:0]     bankFull,
    output logic                                  outValid,
    output bankDrainPkg::bankIdx_t                outBank,
    output bankDrainPkg::bankWord_t               outData,
    output logic                                  recValid,
    output bankDrainPkg::bankIdx_t                recBank,
    output logic [bankDrainPkg::LenWidth-1:0]     recLen,
    input  logic                                  recPop
);

    drainIf drain ();

    bankStore store (
        .clk      (clk),
        .rst_n    (rst_n),
        .wrEn     (wrEn),
        .wrBank   (wrBank),
        .wrData   (wrData),
        .bankFull (bankFull),
        .drain    (drain.store)
    );

    bankGroupArb arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .bankValid (bankValid),
        .drain     (drain.arb)
    );

    drainCollector coll (
        .clk      (clk),
        .rst_n    (rst_n),
        .drain    (drain.coll),
        .outValid (outValid),
        .outBank  (outBank),
        .outData  (outData),
        .recPop   (recPop),
        .recValid (recValid),
        .recBank  (recBank),
        .recLen   (recLen)
    );

endmodule

// ==== tbClkGen.sv ====
`timescale 1ns/1ps

module tbClkGen #(
    parameter int PeriodNs = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PeriodNs / 2) clk = ~clk;   // half period per phase
        end
    end

endmodule

// ==== bankDrainTb.sv ====
`timescale 1ns/1ps

module bankDrainTb;

    localparam int NumCycles  = 3000;
    localparam int DrainLimit = 400;   // cycles allowed for the final drain

    logic clk, rst_n, wrEn, start, recPop, outValid, recValid;
    logic [bankDrainPkg::NumBanks-1:0] bankValid, bankFull;
    logic [bankDrainPkg::LenWidth-1:0] recLen, mCount;
    bankDrainPkg::bankIdx_t            wrBank, outBank, recBank, expBank, mBurstBank;
    bankDrainPkg::bankWord_t           wrData, outData, expData;
    bankDrainPkg::bankWord_t           mQueue [bankDrainPkg::NumBanks][$];
    bankDrainPkg::burstRec_t           mRecs[$];
    logic                              expValid, stepStart;
    int                                mCur;   // -1 while idle, else the bank in its burst
    int                                holdCnt, waitCnt;

    tbClkGen #(.PeriodNs(40)) clkGen (.clk(clk));

    bankDrainTop bankDrainTop_i (.clk(clk), .rst_n(rst_n), .wrEn(wrEn), .wrBank(wrBank),
        .wrData(wrData), .bankValid(bankValid), .start(start), .bankFull(bankFull),
        .outValid(outValid), .outBank(outBank), .outData(outData), .recValid(recValid),
        .recBank(recBank), .recLen(recLen), .recPop(recPop));

    task automatic checkEq(input logic [31:0] got, input logic [31:0] expected, input string what);
        if (got !== expected) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic driveInputs(input bit finalDrain);
        if (finalDrain) begin
            start     = 1'b1;
            bankValid = '1;
            wrEn      = 1'b0;
            recPop    = 1'b1;
        end else begin
            if (holdCnt == 0) begin
                start     = ($urandom % 4) != 0;
                bankValid = 4'($urandom | $urandom);   // each level high 3 times in 4
                holdCnt   = 2 + $urandom % 6;
            end else begin
                holdCnt--;
            end
            wrBank = 2'($urandom);
            wrData = 16'($urandom);
            wrEn   = (($urandom % 2) == 0) && (mQueue[wrBank].size() < bankDrainPkg::QueueDepth);
            recPop = ($urandom % 2) == 0;
        end
    endtask

    // what the next rising edge does, from the model state and the driven inputs
    task automatic modelStep();
        logic [bankDrainPkg::NumBanks-1:0] req;
        bankDrainPkg::burstRec_t           rec;
        logic                              grant, done, recWasFull;
        int                                gIdx, nextCur;
        for (int b = 0; b < bankDrainPkg::NumBanks; b++) req[b] = mQueue[b].size() != 0;
        grant   = 1'b0;
        done    = 1'b0;
        gIdx    = 0;
        nextCur = mCur;
        if (start && mCur < 0) begin
            for (int b = 0; b < bankDrainPkg::NumBanks && !grant; b++) begin
                if (req[b]) begin   // lowest requester
                    grant   = 1'b1;
                    gIdx    = b;
                    nextCur = b;
                end
            end
        end else if (start && req[mCur] && bankValid[mCur]) begin
            grant = 1'b1;
            gIdx  = mCur;
        end else if (start) begin
            done    = 1'b1;
            nextCur = -1;
            for (int k = 1; k < bankDrainPkg::NumBanks && nextCur < 0; k++) begin
                if (req[(mCur + k) % bankDrainPkg::NumBanks]) nextCur = (mCur + k) % 4;
            end
        end
        recWasFull = mRecs.size() == bankDrainPkg::RecDepth;
        if (recPop && mRecs.size() != 0) void'(mRecs.pop_front());
        if (done && mCount != 0 && !recWasFull) begin
            rec.bank = mBurstBank;
            rec.len  = mCount;
            mRecs.push_back(rec);
        end
        expValid  = grant;
        stepStart = start;
        if (grant) begin
            expBank    = 2'(gIdx);
            expData    = mQueue[gIdx].pop_front();
            mBurstBank = 2'(gIdx);
        end
        if (done) mCount = '0;
        else if (grant) mCount = mCount + 1'b1;   // 4-bit length wraps like the record field
        if (wrEn) mQueue[wrBank].push_back(wrData);
        mCur = nextCur;
    endtask

    task automatic compareOutputs();
        if (!stepStart) checkEq(outValid, 1'b0, "outValid while start low");
        checkEq(outValid, expValid, "outValid");
        if (expValid) begin
            checkEq(outBank, expBank, "outBank");
            checkEq(outData, expData, "outData");
        end
        checkEq(recValid, mRecs.size() != 0, "recValid");
        if (mRecs.size() != 0) begin
            checkEq(recBank, mRecs[0].bank, "recBank");
            checkEq(recLen, mRecs[0].len, "recLen");
        end
        for (int b = 0; b < bankDrainPkg::NumBanks; b++) begin
            checkEq(bankFull[b], mQueue[b].size() == bankDrainPkg::QueueDepth, "bankFull");
        end
    endtask

    function automatic bit modelIdle();
        bit idle;
        idle = (mCur < 0) && (mRecs.size() == 0) && !expValid;
        for (int b = 0; b < bankDrainPkg::NumBanks; b++) idle &= mQueue[b].size() == 0;
        return idle;
    endfunction

    initial begin
        void'($urandom(32'h4cdb_8bae));
        rst_n     = 1'b0;
        wrEn      = 1'b0;
        wrBank    = '0;
        wrData    = '0;
        bankValid = '0;
        start     = 1'b0;
        recPop    = 1'b0;
        mCur      = -1;
        mCount    = '0;
        mBurstBank = '0;
        expValid  = 1'b0;
        stepStart = 1'b0;
        holdCnt   = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int n = 0; n < NumCycles; n++) begin
            driveInputs(1'b0);
            modelStep();
            @(negedge clk);
            compareOutputs();
        end
        waitCnt = 0;
        while (!modelIdle()) begin
            if (waitCnt == DrainLimit) begin
                $display("timeout: queues and records not drained after %0d cycles", DrainLimit);
                $display(">>> FAIL");
                $fatal(1, "drain timeout");
            end else begin
                driveInputs(1'b1);
                modelStep();
                @(negedge clk);
                compareOutputs();
                waitCnt++;
            end
        end
        // start and all valid levels stay high, so any word left in a queue would come out
        repeat (4) begin
            @(negedge clk);
            checkEq(outValid, 1'b0, "outValid after drain");
            checkEq(recValid, 1'b0, "recValid after drain");
            checkEq(bankFull, '0, "bankFull after drain");
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== bankDrainTop.f ====
bankDrainPkg.sv
drainIf.sv
bankFifo.sv
bankStore.sv
bankGroupArb.sv
drainCollector.sv
bankDrainTop.sv
tbClkGen.sv
bankDrainTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
verilator --binary --timing -Wno-fatal --top-module bankDrainTb -f bankDrainTop.f -o simv
./obj_dir/simv | tee sim.log
grep -q '^>>> PASS$' sim.log
echo "simulation passed"
